// ==== src.f ====
+incdir+common
common/core_pkg.sv
frontend/fetch_unit.sv
frontend/instr_decoder.sv
execute/exec_unit.sv
logic/reg_file.sv
logic/cpu_core.sv
sim/tb_core.sv

// ==== sim/tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module tb_core;

   typedef core_pkg::word_t word_t;
   typedef core_pkg::regAddr_t regAddr_t;

   // one reference step: next pc, taken control transfer and an optional store
   typedef struct packed {
      word_t nextPc;
      logic  taken;
      logic  store;
      word_t addr;
      word_t data;
   } stepResult_t;

   // a fetch slot, check is low for the slot killed behind a taken transfer
   typedef struct packed {
      logic  check;
      word_t pc;
   } fetchExp_t;

   typedef struct packed {
      word_t addr;
      word_t data;
   } storeExp_t;

   localparam int RUN_TIMEOUT = 400;
   localparam int MODEL_STEPS = 200;

   logic      clk;
   logic      rst;
   word_t     pc;
   word_t     instr;
   logic      memWrite;
   word_t     dataAddr;
   word_t     writeData;
   word_t     readData;
   word_t     imem [0:127];
   word_t     dmem [0:63];
   word_t     mRegs [0:31];
   word_t     mMem [0:63];
   word_t     prog [$];
   word_t     trapProg [$];
   fetchExp_t fetchQ [$];
   storeExp_t storeQ [$];
   fetchExp_t expFetch;
   storeExp_t expStore;
   integer    seed;
   int        errorCount;
   int        checkCount;
   logic      checking;

   cpu_core u_dut (
      .clk       (clk),
      .rst       (rst),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .readData  (readData)
   );

   // both memories answer combinationally
   assign instr = imem[pc[8:2]];
   assign readData = dmem[dataAddr[7:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         dmem[dataAddr[7:2]] <= writeData;
      end
   end

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t encR(input logic [9:0] f, input regAddr_t rd, rs1, rs2);
      return {f[9:3], rs2, rs1, f[2:0], rd, `CORE_OP_OP};
   endfunction

   function automatic word_t encI(input logic [6:0] op, input logic [2:0] f3,
                                  input regAddr_t rd, rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   // store word with x0 as base
   function automatic word_t encSw(input regAddr_t rs2, input logic [11:0] imm);
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `CORE_OP_STORE};
   endfunction

   function automatic word_t encB(input logic [2:0] f3, input regAddr_t rs1, rs2,
                                  input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `CORE_OP_BRANCH};
   endfunction

   function automatic word_t encJal(input regAddr_t rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `CORE_OP_JAL};
   endfunction

   function automatic word_t dataFill(input int i);
      return (i * 32'h0127_4a3b) ^ 32'h5a5a_0000;
   endfunction

   // instruction set model of the supported subset
   function automatic stepResult_t stepIss(input word_t ipc, input word_t ins);
      stepResult_t res;
      word_t       a;
      word_t       b;
      word_t       immI;
      word_t       addr;
      word_t       val;
      logic        wr;
      logic        bad;
      res = '0;
      res.nextPc = ipc + 32'd4;
      a = mRegs[ins[19:15]];
      b = mRegs[ins[24:20]];
      immI = {{20{ins[31]}}, ins[31:20]};
      addr = a + immI;
      val = '0;
      wr = 1'b1;
      bad = 1'b0;
      case (ins[6:0])
         `CORE_OP_OP: begin
            case ({ins[31:25], ins[14:12]})
               10'h000: val = a + b;
               10'h100: val = a - b;
               10'h007: val = a & b;
               10'h006: val = a | b;
               10'h004: val = a ^ b;
               10'h002: val = {31'd0, $signed(a) < $signed(b)};
               default: bad = 1'b1;
            endcase
         end
         `CORE_OP_OPIMM: begin
            case (ins[14:12])
               3'b000:  val = a + immI;
               3'b111:  val = a & immI;
               3'b110:  val = a | immI;
               3'b100:  val = a ^ immI;
               default: bad = 1'b1;
            endcase
         end
         `CORE_OP_LUI: val = {ins[31:12], 12'd0};
         `CORE_OP_LOAD: begin
            bad = (ins[14:12] != 3'b010);
            val = mMem[addr[7:2]];
         end
         `CORE_OP_STORE: begin
            wr = 1'b0;
            bad = (ins[14:12] != 3'b010);
            res.store = 1'b1;
            res.addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            res.data = b;
         end
         `CORE_OP_BRANCH: begin
            wr = 1'b0;
            bad = (ins[14:13] != 2'b00);
            // funct3 bit 0 picks BNE over BEQ
            res.taken = ins[12] ? (a != b) : (a == b);
            if (res.taken) begin
               res.nextPc = ipc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         `CORE_OP_JAL: begin
            val = ipc + 32'd4;
            res.taken = 1'b1;
            res.nextPc = ipc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         default: bad = 1'b1;
      endcase
      if (bad) begin
         res = '0;
         res.nextPc = `CORE_TRAP_VECTOR;
      end else begin
         if (wr && (ins[11:7] != 5'd0)) begin
            mRegs[ins[11:7]] = val;
         end
         if (res.store) begin
            mMem[res.addr[7:2]] = res.data;
         end
      end
      return res;
   endfunction

   task automatic checkValue(input string name, input word_t actual, input word_t expected);
      checkCount++;
      if (actual !== expected) begin
         $display("error %s: got %h, expected %h", name, actual, expected);
         errorCount++;
      end
   endtask

   // mid-cycle sampling, all DUT outputs are settled here
   always @(negedge clk) begin
      if (checking) begin
         if (memWrite) begin
            if (storeQ.size() == 0) begin
               $display("store to address %h was not expected", dataAddr);
               errorCount++;
            end else begin
               expStore = storeQ.pop_front();
               checkValue("dataAddr", dataAddr, expStore.addr);
               checkValue("writeData", writeData, expStore.data);
            end
         end
         if (fetchQ.size() != 0) begin
            expFetch = fetchQ.pop_front();
            if (expFetch.check) begin
               checkValue("pc", pc, expFetch.pc);
            end
         end
      end
   end

   task automatic loadMemories();
      for (int i = 0; i < 128; i++) begin
         // filler NOP carries its word index in the immediate
         imem[i] = encI(`CORE_OP_OPIMM, 3'b000, 5'd0, 5'd0, i[11:0]);
      end
      foreach (prog[k]) begin
         imem[k] = prog[k];
      end
      foreach (trapProg[k]) begin
         imem[(`CORE_TRAP_VECTOR >> 2) + k] = trapProg[k];
      end
      for (int i = 0; i < 64; i++) begin
         dmem[i] = dataFill(i);
         mMem[i] = dataFill(i);
      end
      for (int i = 0; i < 32; i++) begin
         mRegs[i] = '0;
      end
   endtask

   // runs the model up to the final self loop and queues what the DUT must show
   task automatic buildExpected(input string name);
      word_t       mpc;
      stepResult_t res;
      int          steps;
      logic        done;
      fetchQ.delete();
      storeQ.delete();
      mpc = `CORE_RESET_PC;
      steps = 0;
      done = 1'b0;
      while (!done && (steps < MODEL_STEPS)) begin
         res = stepIss(mpc, imem[mpc[8:2]]);
         fetchQ.push_back({1'b1, mpc});
         if (res.taken) begin
            fetchQ.push_back({1'b0, mpc + 32'd4});
         end
         if (res.store) begin
            storeQ.push_back({res.addr, res.data});
         end
         done = (res.nextPc == mpc);
         mpc = res.nextPc;
         steps++;
      end
      if (!done) begin
         $display("reference model of program %s never reached its final loop", name);
         errorCount++;
      end
   endtask

   task automatic runProgram(input string name);
      int cycles;
      @(posedge clk);
      rst <= 1'b1;
      checking = 1'b0;
      // memories change only once the execute register holds a bubble
      @(posedge clk);
      @(negedge clk);
      loadMemories();
      buildExpected(name);
      repeat (7) @(posedge clk);
      rst <= 1'b0;
      checking = 1'b1;
      cycles = 0;
      while (((fetchQ.size() != 0) || (storeQ.size() != 0)) && (cycles < RUN_TIMEOUT)) begin
         @(posedge clk);
         cycles++;
      end
      if ((fetchQ.size() != 0) || (storeQ.size() != 0)) begin
         $display("timeout: program %s did not reach its final loop in time", name);
         errorCount++;
         fetchQ.delete();
         storeQ.delete();
      end
      // a few turns of the final loop catch a stray store
      repeat (4) @(posedge clk);
      checking = 1'b0;
   endtask

   task automatic buildAluProgram();
      word_t       rnd;
      int          sel;
      regAddr_t    rd;
      regAddr_t    rs1;
      regAddr_t    rs2;
      logic [11:0] imm;
      prog.delete();
      trapProg.delete();
      // random start values in x1 to x7
      for (int r = 1; r < 8; r++) begin
         rnd = $random(seed);
         prog.push_back({rnd[31:12], r[4:0], `CORE_OP_LUI});
         prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, r[4:0], r[4:0], rnd[11:0]));
      end
      for (int i = 0; i < 14; i++) begin
         rnd = $random(seed);
         sel = rnd[3:0] % 11;
         rd = (i == 3) ? 5'd0 : {2'b00, rnd[6:4]};
         rs1 = {2'b00, rnd[9:7]};
         rs2 = {2'b00, rnd[12:10]};
         imm = rnd[31:20];
         case (sel)
            0:       prog.push_back(encR(10'h000, rd, rs1, rs2));
            1:       prog.push_back(encR(10'h100, rd, rs1, rs2));
            2:       prog.push_back(encR(10'h007, rd, rs1, rs2));
            3:       prog.push_back(encR(10'h006, rd, rs1, rs2));
            4:       prog.push_back(encR(10'h004, rd, rs1, rs2));
            5:       prog.push_back(encR(10'h002, rd, rs1, rs2));
            6:       prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, rd, rs1, imm));
            7:       prog.push_back(encI(`CORE_OP_OPIMM, 3'b111, rd, rs1, imm));
            8:       prog.push_back(encI(`CORE_OP_OPIMM, 3'b110, rd, rs1, imm));
            9:       prog.push_back(encI(`CORE_OP_OPIMM, 3'b100, rd, rs1, imm));
            default: prog.push_back({rnd[31:12], rd, `CORE_OP_LUI});
         endcase
         // every result lands in its own data word
         prog.push_back(encSw(rd, {i[9:0], 2'b00}));
      end
      prog.push_back(encJal(5'd0, 21'd0));
   endtask

   task automatic buildLoadProgram();
      word_t rnd;
      rnd = $random(seed);
      prog.delete();
      trapProg.delete();
      // load result used by the very next instruction
      prog.push_back(encI(`CORE_OP_LOAD, 3'b010, 5'd5, 5'd0, {6'd0, rnd[3:0], 2'b00}));
      prog.push_back(encR(10'h000, 5'd6, 5'd5, 5'd5));
      prog.push_back(encSw(5'd6, 12'h080));
      prog.push_back(encI(`CORE_OP_LOAD, 3'b010, 5'd7, 5'd0, {6'd0, rnd[7:4], 2'b00}));
      prog.push_back(encSw(5'd7, 12'h084));
      prog.push_back(encJal(5'd0, 21'd0));
   endtask

   task automatic buildBranchProgram();
      word_t rnd;
      rnd = $random(seed);
      prog.delete();
      trapProg.delete();
      prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, 5'd1, 5'd0, rnd[11:0]));
      prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, 5'd2, 5'd0, rnd[11:0]));
      prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, 5'd3, 5'd0, rnd[11:0] ^ 12'h001));
      // each taken transfer skips a store that must never show up
      prog.push_back(encB(3'b000, 5'd1, 5'd2, 13'd8));
      prog.push_back(encSw(5'd1, 12'h0c0));
      prog.push_back(encB(3'b001, 5'd1, 5'd3, 13'd8));
      prog.push_back(encSw(5'd1, 12'h0c4));
      // not taken, the store right behind must happen
      prog.push_back(encB(3'b000, 5'd1, 5'd3, 13'd8));
      prog.push_back(encSw(5'd3, 12'h0c8));
      prog.push_back(encB(3'b001, 5'd1, 5'd2, 13'd8));
      prog.push_back(encSw(5'd2, 12'h0cc));
      prog.push_back(encJal(5'd10, 21'd8));
      prog.push_back(encSw(5'd1, 12'h0d0));
      // link register holds the address after the JAL
      prog.push_back(encSw(5'd10, 12'h0d4));
      prog.push_back(encJal(5'd0, 21'd0));
   endtask

   task automatic buildTrapProgram();
      word_t rnd;
      rnd = $random(seed);
      prog.delete();
      trapProg.delete();
      prog.push_back(encI(`CORE_OP_OPIMM, 3'b000, 5'd1, 5'd0, rnd[11:0]));
      // MUL, outside the supported subset
      prog.push_back(encR(10'h008, 5'd1, 5'd1, 5'd1));
      prog.push_back(encSw(5'd1, 12'h0e0));
      trapProg.push_back(encI(`CORE_OP_OPIMM, 3'b000, 5'd9, 5'd0, rnd[23:12]));
      trapProg.push_back(encSw(5'd9, 12'h0e4));
      trapProg.push_back(encSw(5'd1, 12'h0e8));
      trapProg.push_back(encJal(5'd0, 21'd0));
   endtask

   initial begin
      rst = 1'b1;
      checking = 1'b0;
      errorCount = 0;
      checkCount = 0;
      seed = 32'hdabb_4c9c;
      buildAluProgram();
      runProgram("alu");
      buildLoadProgram();
      runProgram("load");
      buildBranchProgram();
      runProgram("branch");
      buildTrapProgram();
      runProgram("trap");
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
   input  logic            clk,
   input  logic            rst,
   // instruction memory, read combinationally outside
   output core_pkg::word_t pc,
   input  core_pkg::word_t instr,
   // data memory
   output logic            memWrite,
   output core_pkg::word_t dataAddr,
   output core_pkg::word_t writeData,
   input  core_pkg::word_t readData
);

   core_pkg::decoded_t decoded;
   logic               illegal;
   logic               redirect;
   core_pkg::word_t    redirectPc;
   logic               flush;
   core_pkg::regAddr_t rs1;
   core_pkg::regAddr_t rs2;
   core_pkg::word_t    rdData1;
   core_pkg::word_t    rdData2;
   logic               wrEn;
   core_pkg::regAddr_t wrAddr;
   core_pkg::word_t    wrData;

   // kill the instruction in decode on a redirect or a trap
   assign flush = redirect || illegal;

   fetch_unit uFetch (
      .clk        (clk),
      .rst        (rst),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .illegal    (illegal),
      .pc         (pc)
   );

   instr_decoder uDecoder (
      .instr   (instr),
      .pc      (pc),
      .decoded (decoded),
      .illegal (illegal)
   );

   exec_unit uExec (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .decoded    (decoded),
      .rs1        (rs1),
      .rs2        (rs2),
      .rdData1    (rdData1),
      .rdData2    (rdData2),
      .wrEn       (wrEn),
      .wrAddr     (wrAddr),
      .wrData     (wrData),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .dataAddr   (dataAddr),
      .writeData  (writeData),
      .memWrite   (memWrite),
      .readData   (readData)
   );

   reg_file uRegFile (
      .clk     (clk),
      .rst     (rst),
      .rs1     (rs1),
      .rs2     (rs2),
      .rdData1 (rdData1),
      .rdData2 (rdData2),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  core_pkg::regAddr_t rs1,
   input  core_pkg::regAddr_t rs2,
   output core_pkg::word_t    rdData1,
   output core_pkg::word_t    rdData2,
   input  logic               wrEn,
   input  core_pkg::regAddr_t wrAddr,
   input  core_pkg::word_t    wrData
);

   // x0 has no storage
   core_pkg::word_t regs [1:31];

   // combinational reads, x0 reads as zero
   assign rdData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rdData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrAddr != 5'd0)) begin
         regs[wrAddr] <= wrData;
      end
   end

endmodule

`default_nettype wire

// ==== execute/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module exec_unit (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  core_pkg::decoded_t  decoded,
   // register file read side
   output core_pkg::regAddr_t  rs1,
   output core_pkg::regAddr_t  rs2,
   input  core_pkg::word_t     rdData1,
   input  core_pkg::word_t     rdData2,
   // register file write side
   output logic                wrEn,
   output core_pkg::regAddr_t  wrAddr,
   output core_pkg::word_t     wrData,
   // control transfer back to fetch
   output logic                redirect,
   output core_pkg::word_t     redirectPc,
   // data memory port
   output core_pkg::word_t     dataAddr,
   output core_pkg::word_t     writeData,
   output logic                memWrite,
   input  core_pkg::word_t     readData
);

   core_pkg::decoded_t exRec;
   core_pkg::ctrl_t    exCtrl;
   core_pkg::word_t    opB;
   core_pkg::word_t    aluResult;
   core_pkg::word_t    pcPlus4;
   logic               lessThan;
   logic               regsEqual;
   logic               branchTaken;

   // decode to execute register, a flush loads a bubble
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         exRec <= '0;
      end else begin
         exRec <= decoded;
      end
   end

   assign exCtrl = exRec.ctrl;

   assign rs1 = exRec.rs1;
   assign rs2 = exRec.rs2;

   // alu
   assign opB = exCtrl.aluSrc ? exRec.imm : rdData2;
   assign lessThan = $signed(rdData1) < $signed(opB);

   always_comb begin
      case (exCtrl.aluOp)
         `CORE_ALU_ADD:   aluResult = rdData1 + opB;
         `CORE_ALU_SUB:   aluResult = rdData1 - opB;
         `CORE_ALU_AND:   aluResult = rdData1 & opB;
         `CORE_ALU_OR:    aluResult = rdData1 | opB;
         `CORE_ALU_XOR:   aluResult = rdData1 ^ opB;
         `CORE_ALU_SLT:   aluResult = {{(`CORE_XLEN-1){1'b0}}, lessThan};
         `CORE_ALU_PASSB: aluResult = opB;
         default:         aluResult = '0;
      endcase
   end

   // branch and jump resolution
   assign regsEqual = (rdData1 == rdData2);

   always_comb begin
      case (exCtrl.branchType)
         `CORE_BR_EQ: branchTaken = regsEqual;
         `CORE_BR_NE: branchTaken = !regsEqual;
         default:     branchTaken = 1'b0;
      endcase
   end

   // both branches and JAL are pc-relative
   assign redirect = exCtrl.valid && (branchTaken || exCtrl.jump);
   assign redirectPc = exRec.pc + exRec.imm;

   // memory access, address comes from the alu adder
   assign dataAddr = aluResult;
   assign writeData = rdData2;
   assign memWrite = exCtrl.valid && exCtrl.memWrite;

   // write back, lands on the edge that loads the next instruction
   assign pcPlus4 = exRec.pc + `CORE_XLEN'd4;
   assign wrEn = exCtrl.valid && exCtrl.regWrite;
   assign wrAddr = exRec.rd;

   always_comb begin
      if (exCtrl.memToReg) begin
         wrData = readData;
      end else if (exCtrl.linkPc) begin
         wrData = pcPlus4;
      end else begin
         wrData = aluResult;
      end
   end

endmodule

`default_nettype wire

// ==== frontend/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module instr_decoder (
   input  core_pkg::word_t    instr,
   input  core_pkg::word_t    pc,
   output core_pkg::decoded_t decoded,
   output logic               illegal
);

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   core_pkg::word_t immI;
   core_pkg::word_t immS;
   core_pkg::word_t immB;
   core_pkg::word_t immU;
   core_pkg::word_t immJ;
   core_pkg::word_t imm;
   core_pkg::ctrl_t ctrl;
   logic            known;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // sign-extended immediates for each format
   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      known = 1'b1;
      ctrl = '0;
      imm = '0;
      case (opcode)
         `CORE_OP_OP: begin
            ctrl.regWrite = 1'b1;
            case ({funct7, funct3})
               {`CORE_F7_BASE, `CORE_F3_ADDSUB}: ctrl.aluOp = `CORE_ALU_ADD;
               {`CORE_F7_ALT, `CORE_F3_ADDSUB}:  ctrl.aluOp = `CORE_ALU_SUB;
               {`CORE_F7_BASE, `CORE_F3_AND}:    ctrl.aluOp = `CORE_ALU_AND;
               {`CORE_F7_BASE, `CORE_F3_OR}:     ctrl.aluOp = `CORE_ALU_OR;
               {`CORE_F7_BASE, `CORE_F3_XOR}:    ctrl.aluOp = `CORE_ALU_XOR;
               {`CORE_F7_BASE, `CORE_F3_SLT}:    ctrl.aluOp = `CORE_ALU_SLT;
               default:                          known = 1'b0;
            endcase
         end
         `CORE_OP_OPIMM: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc = 1'b1;
            imm = immI;
            case (funct3)
               `CORE_F3_ADDSUB: ctrl.aluOp = `CORE_ALU_ADD;
               `CORE_F3_AND:    ctrl.aluOp = `CORE_ALU_AND;
               `CORE_F3_OR:     ctrl.aluOp = `CORE_ALU_OR;
               `CORE_F3_XOR:    ctrl.aluOp = `CORE_ALU_XOR;
               default:         known = 1'b0;
            endcase
         end
         `CORE_OP_LUI: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = `CORE_ALU_PASSB;
            imm = immU;
         end
         `CORE_OP_LOAD: begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = `CORE_ALU_ADD;
            imm = immI;
            known = (funct3 == `CORE_F3_WORD);
         end
         `CORE_OP_STORE: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = `CORE_ALU_ADD;
            imm = immS;
            known = (funct3 == `CORE_F3_WORD);
         end
         `CORE_OP_BRANCH: begin
            imm = immB;
            case (funct3)
               `CORE_F3_BEQ: ctrl.branchType = `CORE_BR_EQ;
               `CORE_F3_BNE: ctrl.branchType = `CORE_BR_NE;
               default:      known = 1'b0;
            endcase
         end
         `CORE_OP_JAL: begin
            ctrl.regWrite = 1'b1;
            ctrl.jump = 1'b1;
            ctrl.linkPc = 1'b1;
            imm = immJ;
         end
         default: known = 1'b0;
      endcase
      // unmatched encodings carry no enables at all
      if (!known) begin
         ctrl = '0;
      end
      ctrl.valid = known;
   end

   assign decoded.ctrl = ctrl;
   assign decoded.pc = pc;
   assign decoded.rs1 = instr[19:15];
   assign decoded.rs2 = instr[24:20];
   assign decoded.rd = instr[11:7];
   assign decoded.imm = imm;
   assign illegal = !known;

endmodule

`default_nettype wire

// ==== frontend/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module fetch_unit (
   input  logic            clk,
   input  logic            rst,
   // taken branch or jump resolved in execute
   input  logic            redirect,
   input  core_pkg::word_t redirectPc,
   // illegal encoding seen by the decoder this cycle
   input  logic            illegal,
   output core_pkg::word_t pc
);

   core_pkg::word_t pcReg;
   core_pkg::word_t pcPlus4;
   core_pkg::word_t nextPc;

   assign pcPlus4 = pcReg + `CORE_XLEN'd4;

   // execute redirect wins over a trap from the younger instruction in decode
   always_comb begin
      if (redirect) begin
         nextPc = redirectPc;
      end else if (illegal) begin
         nextPc = `CORE_TRAP_VECTOR;
      end else begin
         nextPc = pcPlus4;
      end
   end

   // pc moves every cycle, no stall source exists
   always_ff @(posedge clk) begin
      if (rst) begin
         pcReg <= `CORE_RESET_PC;
      end else begin
         pcReg <= nextPc;
      end
   end

   assign pc = pcReg;

endmodule

`default_nettype wire

// ==== common/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

   // one data or address word
   typedef logic [`CORE_XLEN-1:0] word_t;

   // register number, x0 to x31
   typedef logic [4:0] regAddr_t;

   // alu operation, see CORE_ALU_* codes
   typedef logic [2:0] aluOp_t;

   // branch condition, see CORE_BR_* codes
   typedef logic [1:0] branchType_t;

   // control fields produced by the decoder
   typedef struct packed {
      logic        valid;
      logic        regWrite;
      logic        memWrite;
      logic        memToReg;
      // second alu operand is the immediate
      logic        aluSrc;
      aluOp_t      aluOp;
      branchType_t branchType;
      logic        jump;
      // write back pc+4 instead of the alu result
      logic        linkPc;
   } ctrl_t;

   // record handed from decode to execute
   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc;
      regAddr_t rs1;
      regAddr_t rs2;
      regAddr_t rd;
      word_t    imm;
   } decoded_t;

endpackage

`default_nettype wire

// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width and fixed addresses
`define CORE_XLEN          32
`define CORE_RESET_PC      32'h0000_0000
`define CORE_TRAP_VECTOR   32'h0000_0100

// major opcodes, instr[6:0]
`define CORE_OP_OP         7'b0110011
`define CORE_OP_OPIMM      7'b0010011
`define CORE_OP_LUI        7'b0110111
`define CORE_OP_LOAD       7'b0000011
`define CORE_OP_STORE      7'b0100011
`define CORE_OP_BRANCH     7'b1100011
`define CORE_OP_JAL        7'b1101111

// funct3 and funct7 values of the supported subset
`define CORE_F3_ADDSUB     3'b000
`define CORE_F3_SLT        3'b010
`define CORE_F3_XOR        3'b100
`define CORE_F3_OR         3'b110
`define CORE_F3_AND        3'b111
`define CORE_F3_WORD       3'b010
`define CORE_F3_BEQ        3'b000
`define CORE_F3_BNE        3'b001
`define CORE_F7_BASE       7'b0000000
`define CORE_F7_ALT        7'b0100000

// alu operation codes
`define CORE_ALU_ADD       3'd0
`define CORE_ALU_SUB       3'd1
`define CORE_ALU_AND       3'd2
`define CORE_ALU_OR        3'd3
`define CORE_ALU_XOR       3'd4
`define CORE_ALU_SLT       3'd5
`define CORE_ALU_PASSB     3'd6

// branch condition codes
`define CORE_BR_NONE       2'd0
`define CORE_BR_EQ         2'd1
`define CORE_BR_NE         2'd2

`endif
